// ==== hw/bus_pkg.sv ====
// shared bus definitions
`default_nettype none

package bus_pkg;

   localparam int ADDR_W = 30;
   localparam int DATA_W = 32;
   localparam int OPC_W  = 4;

   typedef logic [ADDR_W-1:0] addr_t;   // word address, top two bits pick the window
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [OPC_W-1:0]  opc_t;

   // acknowledge codes as driven by the slave
   typedef enum logic [2:0] {
      ACK_IDLE  = 3'b000,
      ACK_READY = 3'b001,
      ACK_WAIT  = 3'b010,
      ACK_ERROR = 3'b100
   } ack_e;

   typedef enum logic [2:0] {
      BUS_IDLE     = 3'd0,
      BUS_REQ      = 3'd1,   // grant cycle
      BUS_ADDR     = 3'd2,
      BUS_ADDRDATA = 3'd3,   // data phase of a locked transfer
      BUS_DATA     = 3'd4
   } bus_state_e;

   typedef struct packed {
      logic  req;
      logic  lock;    // keep ownership for the next transfer
      opc_t  opc;
      addr_t addr;
      data_t wdata;
   } master_req_t;

   typedef struct packed {
      ack_e  ack;
      data_t rdata;
   } slave_rsp_t;

   localparam logic [1:0] SEL_WINDOW = 2'd3;   // window of the memory slave

   localparam opc_t OPC_NOP   = 4'd0;   // address-only cycle
   localparam opc_t OPC_READ  = 4'd1;
   localparam opc_t OPC_WRITE = 4'd2;

endpackage

`default_nettype wire

// ==== hw/rr_arbiter.sv ====
// two-way round-robin arbiter
`timescale 1ns/1ns
`default_nettype none

module rr_arbiter (
   input  wire logic clk,
   input  wire logic reset,
   input  wire logic request_0,
   input  wire logic request_1,
   input  wire logic arbitrate,
   output logic      win_0,
   output logic      win_1
);

   logic last_1;   // master 1 won the last grant

   // a lone requester wins, on a tie the one that lost last time
   assign win_0 = arbitrate && request_0 && (!request_1 || last_1);
   assign win_1 = arbitrate && request_1 && (!request_0 || !last_1);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         last_1 <= 1'b1;   // master 0 first after reset
      end
      else if (win_0)
      begin
         last_1 <= 1'b0;
      end
      else if (win_1)
      begin
         last_1 <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== hw/bus_cont.sv ====
// bus phase controller
`timescale 1ns/1ns
`default_nettype none

module bus_cont #(
   parameter int TOUT_LIMIT = 255
) (
   input  wire logic                 clk,
   input  wire logic                 reset,
   input  wire bus_pkg::master_req_t bus_req,
   input  wire bus_pkg::slave_rsp_t  bus_rsp,
   input  wire logic                 m0_request,
   input  wire logic                 m1_request,
   output logic                      gnt_0,
   output logic                      gnt_1,
   output logic                      sel,
   output logic                      tout
);

   import bus_pkg::*;

   localparam int CNT_W = $clog2(TOUT_LIMIT + 1);

   bus_state_e       state;
   bus_state_e       state_d;
   logic [CNT_W-1:0] tout_cnt;    // cycles spent in the data phase
   logic             owner_1;     // current owner is master 1
   logic             is_nop;
   logic             map_hit;
   logic             data_phase;
   logic             xfer_done;
   logic             retire;
   logic             locked;
   logic             arbitrate;
   logic             req_0_m;
   logic             req_1_m;
   logic             win_0;
   logic             win_1;

   assign is_nop     = (bus_req.opc == OPC_NOP);
   assign map_hit    = bus_req.req && !is_nop && (bus_req.addr[ADDR_W-1 -: 2] == SEL_WINDOW);
   assign data_phase = (state == BUS_ADDRDATA) || (state == BUS_DATA);
   assign xfer_done  = data_phase && ((bus_rsp.ack == ACK_READY) || (bus_rsp.ack == ACK_ERROR));

   // owner's transfer ends in this cycle
   assign retire = xfer_done || ((state == BUS_ADDR) && is_nop);
   assign locked = (state == BUS_ADDRDATA) || ((state == BUS_ADDR) && bus_req.lock);

   // no ready or error in time, a completing slave wins the tie
   assign tout = data_phase && !xfer_done && (tout_cnt == CNT_W'(TOUT_LIMIT));

   assign arbitrate = (state == BUS_IDLE) || (retire && !locked);

   // the retiring owner still shows req in its last cycle
   assign req_0_m = m0_request && !(retire && !owner_1);
   assign req_1_m = m1_request && !(retire && owner_1);

   rr_arbiter rr_arbiter_i (
      .clk       (clk),
      .reset     (reset),
      .request_0 (req_0_m),
      .request_1 (req_1_m),
      .arbitrate (arbitrate),
      .win_0     (win_0),
      .win_1     (win_1)
   );

   always_comb
   begin
      state_d = state;
      case (state)
         BUS_IDLE:
         begin
            if (win_0 || win_1)
            begin
               state_d = BUS_REQ;
            end
         end
         BUS_REQ:
         begin
            state_d = bus_req.req ? BUS_ADDR : BUS_IDLE;   // locked owner may have quit
         end
         BUS_ADDR:
         begin
            if (!is_nop)
            begin
               state_d = bus_req.lock ? BUS_ADDRDATA : BUS_DATA;
            end
         end
         BUS_ADDRDATA, BUS_DATA:
         begin
            if (tout)
            begin
               state_d = BUS_IDLE;
            end
         end
         default:
         begin
            state_d = BUS_IDLE;
         end
      endcase

      if (retire)
      begin
         if (locked || win_0 || win_1)
         begin
            state_d = BUS_REQ;   // locked owner goes on without a grant
         end
         else
         begin
            state_d = BUS_IDLE;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= BUS_IDLE;
         gnt_0    <= 1'b0;
         gnt_1    <= 1'b0;
         sel      <= 1'b0;
         owner_1  <= 1'b0;
         tout_cnt <= '0;
      end
      else
      begin
         state <= state_d;
         gnt_0 <= win_0;   // one-cycle pulse, arbitration stops in BUS_REQ
         gnt_1 <= win_1;
         if (win_1)
         begin
            owner_1 <= 1'b1;
         end
         else if (win_0)
         begin
            owner_1 <= 1'b0;
         end

         if (state == BUS_REQ)
         begin
            sel <= map_hit;
         end
         else if (retire || tout)
         begin
            sel <= 1'b0;
         end

         tout_cnt <= data_phase ? tout_cnt + 1'b1 : '0;
      end
   end

endmodule

`default_nettype wire

// ==== hw/master_mux.sv ====
// bus owner request multiplexer
`timescale 1ns/1ns
`default_nettype none

module master_mux (
   input  wire logic                 clk,
   input  wire logic                 reset,
   input  wire bus_pkg::master_req_t m0_req,
   input  wire bus_pkg::master_req_t m1_req,
   input  wire logic                 gnt_0,
   input  wire logic                 gnt_1,
   output bus_pkg::master_req_t      bus_req
);

   logic owned;     // some master has been granted since reset
   logic owner_1;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         owned   <= 1'b0;
         owner_1 <= 1'b0;
      end
      else if (gnt_1)
      begin
         owned   <= 1'b1;
         owner_1 <= 1'b1;
      end
      else if (gnt_0)
      begin
         owned   <= 1'b1;
         owner_1 <= 1'b0;
      end
   end

   // grant cycle already shows the new owner
   always_comb
   begin
      if (gnt_1)
         bus_req = m1_req;
      else if (gnt_0)
         bus_req = m0_req;
      else if (!owned)
         bus_req = '0;
      else
         bus_req = owner_1 ? m1_req : m0_req;
   end

endmodule

`default_nettype wire

// ==== hw/mem_slave.sv ====
// memory slave with wait states
`timescale 1ns/1ns
`default_nettype none

module mem_slave #(
   parameter int WAIT_STATES = 2,
   parameter int MEM_WORDS   = 64
) (
   input  wire logic                 clk,
   input  wire logic                 reset,
   input  wire logic                 sel,
   input  wire bus_pkg::master_req_t bus_req,
   output bus_pkg::slave_rsp_t       bus_rsp
);

   import bus_pkg::*;

   localparam int AW = $clog2(MEM_WORDS);
   localparam int WW = $clog2(WAIT_STATES + 2);

   data_t         mem [MEM_WORDS];
   data_t         rdata_q;
   ack_e          ack_q;
   logic [WW-1:0] wait_cnt;    // WAIT_STATES + 1 once the transfer is answered
   logic [AW-1:0] word;
   logic          complete;
   logic          supported;
   logic          is_write;

   assign word      = AW'(bus_req.addr % MEM_WORDS);   // wraps over the memory
   assign complete  = sel && (wait_cnt == WW'(WAIT_STATES));
   assign is_write  = (bus_req.opc == OPC_WRITE);
   assign supported = (bus_req.opc == OPC_READ) || is_write;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ack_q    <= ACK_IDLE;
         wait_cnt <= '0;
      end
      else if (!sel)
      begin
         ack_q    <= ACK_IDLE;
         wait_cnt <= '0;
      end
      else if (wait_cnt < WW'(WAIT_STATES))
      begin
         ack_q    <= ACK_WAIT;
         wait_cnt <= wait_cnt + 1'b1;
      end
      else if (complete)
      begin
         ack_q    <= supported ? ACK_READY : ACK_ERROR;
         wait_cnt <= wait_cnt + 1'b1;
      end
      else
      begin
         ack_q <= ACK_IDLE;   // answered, wait for sel to drop
      end
   end

   always_ff @(posedge clk)
   begin
      if (complete && is_write)
      begin
         mem[word] <= bus_req.wdata;
      end
      if (complete)
      begin
         rdata_q <= (bus_req.opc == OPC_READ) ? mem[word] : '0;
      end
   end

   assign bus_rsp.ack   = ack_q;
   assign bus_rsp.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== hw/bus_system.sv ====
// shared bus system top
`timescale 1ns/1ns
`default_nettype none

module bus_system #(
   parameter int TOUT_LIMIT  = 255,
   parameter int WAIT_STATES = 2,
   parameter int MEM_WORDS   = 64
) (
   input  wire logic                 clk,
   input  wire logic                 reset,
   input  wire bus_pkg::master_req_t m0_req,
   input  wire bus_pkg::master_req_t m1_req,
   output wire logic                 gnt_0,
   output wire logic                 gnt_1,
   output wire bus_pkg::slave_rsp_t  bus_rsp,
   output wire logic                 tout
);

   import bus_pkg::*;

   master_req_t bus_req;   // request of the current owner
   logic        sel;

   bus_cont #(
      .TOUT_LIMIT (TOUT_LIMIT)
   ) bus_cont_i (
      .clk        (clk),
      .reset      (reset),
      .bus_req    (bus_req),
      .bus_rsp    (bus_rsp),
      .m0_request (m0_req.req),
      .m1_request (m1_req.req),
      .gnt_0      (gnt_0),
      .gnt_1      (gnt_1),
      .sel        (sel),
      .tout       (tout)
   );

   master_mux master_mux_i (
      .clk     (clk),
      .reset   (reset),
      .m0_req  (m0_req),
      .m1_req  (m1_req),
      .gnt_0   (gnt_0),
      .gnt_1   (gnt_1),
      .bus_req (bus_req)
   );

   mem_slave #(
      .WAIT_STATES (WAIT_STATES),
      .MEM_WORDS   (MEM_WORDS)
   ) mem_slave_i (
      .clk     (clk),
      .reset   (reset),
      .sel     (sel),
      .bus_req (bus_req),
      .bus_rsp (bus_rsp)
   );

endmodule

`default_nettype wire

// ==== tb/bus_system_asserts.sv ====
// bus controller protocol assertions
`timescale 1ns/1ns
`default_nettype none

module bus_cont_asserts (
   input wire logic                clk,
   input wire logic                reset,
   input wire logic                gnt_0,
   input wire logic                gnt_1,
   input wire logic                sel,
   input wire logic                tout,
   input wire bus_pkg::bus_state_e state
);

   import bus_pkg::*;

   a_one_grant : assert property (@(posedge clk) disable iff (reset) !(gnt_0 && gnt_1))
      else $error("gnt_0 and gnt_1 high together");

   a_gnt_0_pulse : assert property (@(posedge clk) disable iff (reset) gnt_0 |=> !gnt_0)
      else $error("gnt_0 longer than one cycle");

   a_gnt_1_pulse : assert property (@(posedge clk) disable iff (reset) gnt_1 |=> !gnt_1)
      else $error("gnt_1 longer than one cycle");

   // no slave select before the address phase
   a_sel_low : assert property (@(posedge clk) disable iff (reset)
      (state == BUS_IDLE || state == BUS_REQ) |-> !sel)
      else $error("sel high in idle or request phase");

   a_tout_pulse : assert property (@(posedge clk) disable iff (reset) tout |=> !tout)
      else $error("tout longer than one cycle");

endmodule

bind bus_cont bus_cont_asserts bus_cont_asserts_i (
   .clk   (clk),
   .reset (reset),
   .gnt_0 (gnt_0),
   .gnt_1 (gnt_1),
   .sel   (sel),
   .tout  (tout),
   .state (state)
);

`default_nettype wire

// ==== tb/bus_system_tb.sv ====
// bus system testbench
`timescale 1ns/1ns
`default_nettype none

module bus_system_tb;

   import bus_pkg::*;

   localparam int TOUT_LIMIT  = 255;
   localparam int WAIT_STATES = 2;
   localparam int MEM_WORDS   = 64;
   localparam int MAX_TESTS   = 32;

   logic        clk;
   logic        reset;
   master_req_t m0_req;
   master_req_t m1_req;
   logic        gnt_0;
   logic        gnt_1;
   slave_rsp_t  bus_rsp;
   logic        tout;

   master_req_t t_req0 [MAX_TESTS];   // one line of the test file each
   master_req_t t_req1 [MAX_TESTS];
   logic [1:0]  t_gnt  [MAX_TESTS];   // 2 means locked owner goes on
   logic [2:0]  t_ack  [MAX_TESTS];
   data_t       t_rdata[MAX_TESTS];
   logic        t_tout [MAX_TESTS];
   int          n_tests;
   logic        loaded;
   int          errors;

   data_t       model_mem [MEM_WORDS];
   master_req_t cur0;                  // request currently held by each master
   master_req_t cur1;
   logic        busy0;
   logic        busy1;
   logic        owner;
   logic        cont;                  // previous transfer kept the lock

   bus_system #(
      .TOUT_LIMIT  (TOUT_LIMIT),
      .WAIT_STATES (WAIT_STATES),
      .MEM_WORDS   (MEM_WORDS)
   ) bus_system_i (
      .clk     (clk),
      .reset   (reset),
      .m0_req  (m0_req),
      .m1_req  (m1_req),
      .gnt_0   (gnt_0),
      .gnt_1   (gnt_1),
      .bus_rsp (bus_rsp),
      .tout    (tout)
   );

   always #10 clk = ~clk;

   task automatic fail_run(input string msg);
   begin
      $display("%s", msg);
      $display("Done: errors found");
      $fatal(1, "simulation stopped");
   end
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
   begin
      if (actual !== expected)
      begin
         errors = errors + 1;
         fail_run($sformatf("error: %s is %h, expected %h", name, actual, expected));
      end
   end
   endtask

   task automatic read_tests();
      int          fd;
      int          r;
      string       line_s;
      logic [31:0] f [14];
   begin
      n_tests = 0;
      fd = $fopen("tb/bus_tests.txt", "r");
      if (fd == 0)
      begin
         fail_run("the test file tb/bus_tests.txt could not be opened");
      end
      while (!$feof(fd) && n_tests < MAX_TESTS)
      begin
         line_s = "";
         r = $fgets(line_s, fd);
         if (line_s.len() < 2 || line_s.getc(0) == "#")
            continue;
         r = $sscanf(line_s, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                     f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                     f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
         if (r != 14)
         begin
            fail_run($sformatf("test file line %0d has %0d fields", n_tests + 1, r));
         end
         t_req0[n_tests]  = {f[0][0], f[1][0], f[2][3:0], f[3][29:0], f[4]};
         t_req1[n_tests]  = {f[5][0], f[6][0], f[7][3:0], f[8][29:0], f[9]};
         t_gnt[n_tests]   = f[10][1:0];
         t_ack[n_tests]   = f[11][2:0];
         t_rdata[n_tests] = f[12];
         t_tout[n_tests]  = f[13][0];
         n_tests = n_tests + 1;
      end
      $fclose(fd);
      if (n_tests == 0)
      begin
         fail_run("the test file holds no tests");
      end
   end
   endtask

   // waits for the next grant pulse and returns the winner
   task automatic wait_grant(output logic [1:0] grantee);
      int k;
   begin
      grantee = 2'd2;
      k       = 0;
      while (grantee == 2'd2)
      begin
         @(negedge clk);
         if (gnt_1)
            grantee = 2'd1;
         else if (gnt_0)
            grantee = 2'd0;
         k = k + 1;
         if (grantee == 2'd2 && k > 8)
            fail_run("no grant was given within 8 cycles");
      end
   end
   endtask

   // both masters ask for an address-only cycle right after reset
   task automatic check_first_tie();
      master_req_t nop_req;
      logic [1:0]  grantee;
   begin
      nop_req     = '0;
      nop_req.req = 1'b1;
      @(posedge clk);
      m0_req <= nop_req;
      m1_req <= nop_req;
      wait_grant(grantee);
      check_value("first grant", 32'(grantee), 32'd0);
      repeat (2) @(posedge clk);
      m0_req <= '0;   // address phase is over
      wait_grant(grantee);
      check_value("second grant", 32'(grantee), 32'd1);
      repeat (2) @(posedge clk);
      m1_req <= '0;
   end
   endtask

   // waits for the grant, follows one transfer to its end and checks it
   task automatic run_transfer(input int i);
      logic [1:0]  grantee;
      master_req_t req;
      int          k;
      int          waits;
      int          idx;
      logic        done;
      logic        mapped;
      logic [2:0]  exp_ack;
      logic        exp_tout;
   begin
      if (cont)
      begin
         @(negedge clk);
         grantee = gnt_1 ? 2'd1 : (gnt_0 ? 2'd0 : 2'd2);
      end
      else
      begin
         wait_grant(grantee);
      end
      check_value("grant", 32'(grantee), 32'(t_gnt[i]));
      if (!cont)
         owner = grantee[0];
      req = owner ? cur1 : cur0;

      // expected response from the bus rules
      mapped = (req.addr[29:28] == SEL_WINDOW);
      idx    = int'(req.addr) % MEM_WORDS;
      exp_tout = 1'b0;
      if (req.opc == OPC_NOP)
         exp_ack = ACK_IDLE;
      else if (!mapped)
      begin
         exp_ack  = ACK_IDLE;
         exp_tout = 1'b1;
      end
      else if (req.opc == OPC_READ || req.opc == OPC_WRITE)
         exp_ack = ACK_READY;
      else
         exp_ack = ACK_ERROR;

      waits = 0;
      k     = 0;
      done  = 1'b0;
      while (!done)
      begin
         @(negedge clk);
         check_value("gnt_0", 32'(gnt_0), 32'd0);   // no grant inside a transfer
         check_value("gnt_1", 32'(gnt_1), 32'd0);
         if (req.opc == OPC_NOP)
            done = 1'b1;                            // ends in the address phase
         else if (bus_rsp.ack == ACK_READY || bus_rsp.ack == ACK_ERROR || tout)
            done = 1'b1;
         else if (bus_rsp.ack == ACK_WAIT)
            waits = waits + 1;
         k = k + 1;
         if (!done && k > TOUT_LIMIT + 10)
            fail_run($sformatf("transfer of test %0d never ended", i + 1));
      end

      check_value("bus_rsp.ack", 32'(bus_rsp.ack), 32'(t_ack[i]));
      check_value("bus_rsp.ack", 32'(bus_rsp.ack), 32'(exp_ack));
      check_value("tout", 32'(tout), 32'(t_tout[i]));
      check_value("tout", 32'(tout), 32'(exp_tout));
      if (exp_ack == ACK_READY || exp_ack == ACK_ERROR)
         check_value("wait cycles", 32'(waits), 32'(WAIT_STATES));
      if (exp_ack == ACK_READY && req.opc == OPC_READ)
      begin
         check_value("bus_rsp.rdata", bus_rsp.rdata, t_rdata[i]);
         check_value("bus_rsp.rdata", bus_rsp.rdata, model_mem[idx]);
      end
      if (exp_ack == ACK_READY && req.opc == OPC_WRITE)
         model_mem[idx] = req.wdata;

      cont = req.lock && !tout;
      if (owner)
         busy1 = 1'b0;
      else
         busy0 = 1'b0;
   end
   endtask

   // watchdog sized from the number of tests
   initial
   begin
      wait (loaded);
      repeat (n_tests * (TOUT_LIMIT + 20)) @(posedge clk);
      fail_run("watchdog expired, the tests did not finish in time");
   end

   initial
   begin
      clk    = 1'b0;
      reset  = 1'b1;
      m0_req = '0;
      m1_req = '0;
      cur0   = '0;
      cur1   = '0;
      busy0  = 1'b0;
      busy1  = 1'b0;
      owner  = 1'b0;
      cont   = 1'b0;
      errors = 0;
      loaded = 1'b0;
      for (int a = 0; a < MEM_WORDS; a++)
         model_mem[a] = '0;
      read_tests();
      loaded = 1'b1;

      repeat (2) @(posedge clk);
      reset <= 1'b0;

      check_first_tie();

      for (int i = 0; i < n_tests; i++)
      begin
         @(posedge clk);
         if (i > 0)
         begin
            if (owner)
               m1_req <= '0;   // finished master drops its request
            else
               m0_req <= '0;
         end
         if (t_req0[i].req)
         begin
            if (busy0)
               fail_run($sformatf("test %0d gives master 0 a request while busy", i + 1));
            m0_req <= t_req0[i];
            cur0  = t_req0[i];
            busy0 = 1'b1;
         end
         if (t_req1[i].req)
         begin
            if (busy1)
               fail_run($sformatf("test %0d gives master 1 a request while busy", i + 1));
            m1_req <= t_req1[i];
            cur1  = t_req1[i];
            busy1 = 1'b1;
         end
         run_transfer(i);
      end

      @(posedge clk);
      m0_req <= '0;
      m1_req <= '0;
      repeat (3) @(posedge clk);

      if (errors == 0)
      begin
         $display("Done: no errors");
         $finish;
      end
      else
      begin
         fail_run("checks failed");
      end
   end

endmodule

`default_nettype wire

// ==== tb/bus_tests.txt ====
# hex columns: m0 req lock opc addr wdata, m1 req lock opc addr wdata,
# then expected grant (2 = locked owner goes on), ack, read data, timeout
1 0 2 30000005 deadbeef 0 0 0 00000000 00000000 0 1 00000000 0
1 0 1 30000005 00000000 0 0 0 00000000 00000000 0 1 deadbeef 0
1 0 2 30000010 11111111 1 0 2 30000011 22222222 1 1 00000000 0
0 0 0 00000000 00000000 1 0 1 30000010 00000000 0 1 00000000 0
1 0 1 30000011 00000000 0 0 0 00000000 00000000 1 1 11111111 0
0 0 0 00000000 00000000 1 0 2 30000012 33333333 0 1 22222222 0
0 0 0 00000000 00000000 0 0 0 00000000 00000000 1 1 00000000 0
1 0 5 30000005 0badc0de 0 0 0 00000000 00000000 0 4 00000000 0
1 0 1 30000005 00000000 0 0 0 00000000 00000000 0 1 deadbeef 0
1 0 1 10000004 00000000 0 0 0 00000000 00000000 0 0 00000000 1
0 0 0 00000000 00000000 1 0 1 30000010 00000000 1 1 11111111 0
1 0 0 30000001 00000000 0 0 0 00000000 00000000 0 0 00000000 0
1 0 1 30000005 00000000 1 1 2 30000020 44444444 1 1 00000000 0
0 0 0 00000000 00000000 1 0 1 30000020 00000000 2 1 44444444 0
0 0 0 00000000 00000000 0 0 0 00000000 00000000 0 1 deadbeef 0
0 0 0 00000000 00000000 1 0 1 30000045 00000000 1 1 deadbeef 0
1 0 2 3000003f 5a5a5a5a 0 0 0 00000000 00000000 0 1 00000000 0
0 0 0 00000000 00000000 1 0 1 3000003f 00000000 1 1 5a5a5a5a 0

// ==== bus_system.f ====
hw/bus_pkg.sv
hw/rr_arbiter.sv
hw/bus_cont.sv
hw/master_mux.sv
hw/mem_slave.sv
hw/bus_system.sv
tb/bus_system_asserts.sv
tb/bus_system_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator and run, pass is found by a search of the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -sv -f bus_system.f \
   --top-module bus_system_tb -o bus_system_sim &&
./obj_dir/bus_system_sim | grep "Done: no errors" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
